//--- Makefile
VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= tlb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/tlb_macros.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/tlb_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_ctrl
    import tlb_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cmd_valid,
    input  wire tlb_cmd_t               cmd,
    input  wire tlb_search_rsp_t        cmd_rsp,
    input  wire tlb_entry_t             rd_entry_in,
    output logic                        wr_en,
    output logic       [`TLB_IDX_W-1:0] wr_index,
    output tlb_entry_t                  wr_entry,
    output logic                        inv_en,
    output logic                        rd_valid,
    output tlb_entry_t                  rd_entry,
    output logic                        srch_done,
    output logic                        srch_hit,
    output logic       [`TLB_IDX_W-1:0] srch_index,
    output logic                        inv_err
);

    localparam int            IW        = `TLB_IDX_W;
    localparam logic [IW-1:0] FILL_LAST = IW'(`TLB_NUM - 1);

    tlb_key_t      key;
    logic          is_wr;
    logic          is_fill;
    logic          is_rd;
    logic          is_srch;
    logic          is_inv;
    logic          bad_op;
    logic [IW-1:0] fill_cnt;

    assign key     = cmd.payload.key;
    assign is_wr   = cmd_valid && (cmd.op == `TLB_CMD_WR);
    assign is_fill = cmd_valid && (cmd.op == `TLB_CMD_FILL);
    assign is_rd   = cmd_valid && (cmd.op == `TLB_CMD_RD);
    assign is_srch = cmd_valid && (cmd.op == `TLB_CMD_SRCH);
    assign is_inv  = cmd_valid && (cmd.op == `TLB_CMD_INV);
    assign bad_op  = key.inv_op > `TLB_INV_OP_MAX;

    assign wr_en    = is_wr || is_fill;
    assign wr_index = is_fill ? fill_cnt : cmd.index;
    assign wr_entry = cmd.payload.entry;
    assign inv_en   = is_inv && !bad_op;

    // fill index wraps at the entry count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (is_fill) begin
            fill_cnt <= (fill_cnt == FILL_LAST) ? '0 : fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            srch_done <= 1'b0;
            srch_hit  <= 1'b0;
            inv_err   <= 1'b0;
        end else begin
            rd_valid  <= is_rd;
            srch_done <= is_srch;
            if (is_srch) begin
                srch_hit <= cmd_rsp.found;
            end
            // sticky until reset
            if (is_inv && bad_op) begin
                inv_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_rd) begin
            rd_entry <= rd_entry_in;
        end
        if (is_srch) begin
            srch_index <= cmd_rsp.index;
        end
    end

    a_cmd_op_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd_valid |-> cmd.op inside {`TLB_CMD_WR, `TLB_CMD_FILL, `TLB_CMD_RD,
                                     `TLB_CMD_SRCH, `TLB_CMD_INV}
    );

endmodule

`default_nettype wire

//--- design/tlb_inv_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_inv_select
    import tlb_pkg::*;
(
    input  wire tlb_entry_t [`TLB_NUM-1:0] entries,
    input  wire tlb_key_t                  key,
    output logic            [`TLB_NUM-1:0] inv_mask
);

    logic [`TLB_NUM-1:0] asid_eq;
    logic [`TLB_NUM-1:0] vppn_eq;
    logic [`TLB_NUM-1:0] glb;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            glb[i]     = entries[i].g;
            asid_eq[i] = entries[i].asid == key.asid;
            // compared at the entry's own page size
            vppn_eq[i] = tlb_vppn_hit(entries[i], key.vppn);
        end
    end

    always_comb begin
        case (key.inv_op)
            5'd0, 5'd1: begin
                inv_mask = '1;
            end
            5'd2: begin
                inv_mask = glb;
            end
            5'd3: begin
                inv_mask = ~glb;
            end
            5'd4: begin
                inv_mask = ~glb & asid_eq;
            end
            5'd5: begin
                inv_mask = ~glb & asid_eq & vppn_eq;
            end
            5'd6: begin
                inv_mask = (glb | asid_eq) & vppn_eq;
            end
            default: begin
                // undefined ops select nothing
                inv_mask = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_lookup
    import tlb_pkg::*;
(
    input  wire tlb_entry_t [`TLB_NUM-1:0] entries,
    input  wire tlb_search_req_t           req,
    output tlb_search_rsp_t                rsp
);

    localparam int IW = `TLB_IDX_W;

    logic [`TLB_NUM-1:0] match;
    logic [IW-1:0]       hit_idx;
    logic                hit;
    logic                odd;
    tlb_entry_t          sel;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            match[i] = entries[i].e
                    && tlb_vppn_hit(entries[i], req.vppn)
                    && (entries[i].g || entries[i].asid == req.asid);
        end
    end

    // scan downwards so the lowest match wins
    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = IW'(i);
            end
        end
    end

    assign hit = |match;
    assign sel = entries[hit_idx];

    // odd half picked by va bit 12, or vppn[8] on large pages
    assign odd = (sel.ps == `TLB_PS_4M) ? req.vppn[8] : req.va_bit12;

    always_comb begin
        rsp = '0;
        if (hit) begin
            rsp.found = 1'b1;
            rsp.index = hit_idx;
            rsp.ps    = sel.ps;
            rsp.page  = odd ? sel.page1 : sel.page0;
        end
    end

endmodule

`default_nettype wire

//--- design/tlb_macros.svh
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// entry count and index width
`define TLB_NUM          16
`define TLB_IDX_W        $clog2(`TLB_NUM)

// legal page size codes
`define TLB_PS_4K        6'd12
`define TLB_PS_4M        6'd21

// command codes on the strobed path
`define TLB_CMD_WR       3'd0
`define TLB_CMD_FILL     3'd1
`define TLB_CMD_RD       3'd2
`define TLB_CMD_SRCH     3'd3
`define TLB_CMD_INV      3'd4

// highest defined invtlb op
`define TLB_INV_OP_MAX   5'd6

`endif

//--- design/tlb_pkg.sv
`default_nettype none

`include "tlb_macros.svh"

package tlb_pkg;

    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [9:0]  asid;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    // padded out to the width of an entry
    typedef struct packed {
        logic [4:0]  inv_op;
        logic [9:0]  asid;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [48:0] pad;
    } tlb_key_t;

    // entry for write and fill, key for search and invalidate
    typedef union packed {
        tlb_entry_t entry;
        tlb_key_t   key;
    } tlb_payload_u;

    typedef struct packed {
        logic [2:0]            op;
        logic [`TLB_IDX_W-1:0] index;
        tlb_payload_u          payload;
    } tlb_cmd_t;

    typedef struct packed {
        logic [18:0] vppn;
        logic        va_bit12;
        logic [9:0]  asid;
    } tlb_search_req_t;

    typedef struct packed {
        logic                  found;
        logic [`TLB_IDX_W-1:0] index;
        logic [5:0]            ps;
        tlb_page_t             page;
    } tlb_search_rsp_t;

    // large pages compare only the pair region
    function automatic logic tlb_vppn_hit(tlb_entry_t ent, logic [18:0] vppn);
        if (ent.ps == `TLB_PS_4M) begin
            return ent.vppn[18:9] == vppn[18:9];
        end
        return ent.vppn == vppn;
    endfunction

endpackage

`default_nettype wire

//--- design/tlb_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_store
    import tlb_pkg::*;
(
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   wr_en,
    input  wire        [`TLB_IDX_W-1:0]           wr_index,
    input  wire tlb_entry_t                       wr_entry,
    input  wire                                   inv_en,
    input  wire        [`TLB_NUM-1:0]             inv_mask,
    input  wire        [`TLB_IDX_W-1:0]           rd_index,
    output tlb_entry_t                            rd_entry,
    output tlb_entry_t [`TLB_NUM-1:0]             entries
);

    // per-entry existence bits
    logic [`TLB_NUM-1:0] e_q;
    tlb_entry_t          body_q [`TLB_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (wr_en) begin
            e_q[wr_index] <= wr_entry.e;
        end else if (inv_en) begin
            e_q <= e_q & ~inv_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            body_q[wr_index] <= wr_entry;
        end
    end

    // merge e back into the exported array
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            entries[i]   = body_q[i];
            entries[i].e = e_q[i];
        end
    end

    assign rd_entry = entries[rd_index];

    // ctrl issues one command per cycle
    a_wr_inv_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_en && inv_en)
    );

    // only 4K and 4M pages are supported by lookup
    a_wr_ps_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_entry.ps == `TLB_PS_4K || wr_entry.ps == `TLB_PS_4M)
    );

endmodule

`default_nettype wire

//--- design/tlb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_top
    import tlb_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire tlb_search_req_t        s0_req,
    output tlb_search_rsp_t             s0_rsp,
    input  wire tlb_search_req_t        s1_req,
    output tlb_search_rsp_t             s1_rsp,
    input  wire                         cmd_valid,
    input  wire tlb_cmd_t               cmd,
    output logic                        rd_valid,
    output tlb_entry_t                  rd_entry,
    output logic                        srch_done,
    output logic                        srch_hit,
    output logic       [`TLB_IDX_W-1:0] srch_index,
    output logic                        inv_err
);

    logic                             wr_en;
    logic            [`TLB_IDX_W-1:0] wr_index;
    tlb_entry_t                       wr_entry;
    logic                             inv_en;
    logic            [`TLB_NUM-1:0]   inv_mask;
    tlb_entry_t                       store_rd_entry;
    tlb_entry_t      [`TLB_NUM-1:0]   entries;
    tlb_search_req_t                  cmd_req;
    tlb_search_rsp_t                  cmd_rsp;

    // only hit and index of the command search are used
    assign cmd_req.vppn     = cmd.payload.key.vppn;
    assign cmd_req.va_bit12 = 1'b0;
    assign cmd_req.asid     = cmd.payload.key.asid;

    tlb_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cmd_rsp     (cmd_rsp),
        .rd_entry_in (store_rd_entry),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .inv_en      (inv_en),
        .rd_valid    (rd_valid),
        .rd_entry    (rd_entry),
        .srch_done   (srch_done),
        .srch_hit    (srch_hit),
        .srch_index  (srch_index),
        .inv_err     (inv_err)
    );

    tlb_store u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .inv_en   (inv_en),
        .inv_mask (inv_mask),
        .rd_index (cmd.index),
        .rd_entry (store_rd_entry),
        .entries  (entries)
    );

    tlb_inv_select u_inv_select (
        .entries  (entries),
        .key      (cmd.payload.key),
        .inv_mask (inv_mask)
    );

    tlb_lookup u_s0_lookup (
        .entries (entries),
        .req     (s0_req),
        .rsp     (s0_rsp)
    );

    tlb_lookup u_s1_lookup (
        .entries (entries),
        .req     (s1_req),
        .rsp     (s1_rsp)
    );

    tlb_lookup u_cmd_lookup (
        .entries (entries),
        .req     (cmd_req),
        .rsp     (cmd_rsp)
    );

endmodule

`default_nettype wire

//--- dv/tlb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_tb
    import tlb_pkg::*;
();

    localparam int N       = `TLB_NUM;
    localparam int IW      = `TLB_IDX_W;
    localparam int TIMEOUT = 20;

    logic                  clk;
    logic                  rst_n;
    tlb_search_req_t       s0_req;
    tlb_search_req_t       s1_req;
    tlb_search_rsp_t       s0_rsp;
    tlb_search_rsp_t       s1_rsp;
    logic                  cmd_valid;
    tlb_cmd_t              cmd;
    logic                  rd_valid;
    tlb_entry_t            rd_entry;
    logic                  srch_done;
    logic                  srch_hit;
    logic [IW-1:0]         srch_index;
    logic                  inv_err;

    // reference state
    tlb_entry_t            model [N];
    logic [IW-1:0]         model_fill;
    logic                  model_err;
    integer                seed;
    integer                errors;

    tlb_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .s0_req     (s0_req),
        .s0_rsp     (s0_rsp),
        .s1_req     (s1_req),
        .s1_rsp     (s1_rsp),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .rd_valid   (rd_valid),
        .rd_entry   (rd_entry),
        .srch_done  (srch_done),
        .srch_hit   (srch_hit),
        .srch_index (srch_index),
        .inv_err    (inv_err)
    );

    always #2 clk = ~clk;

    function automatic int unsigned pick(int unsigned n);
        return {$random(seed)} % n;
    endfunction

    // small pools so that multiple matches are common
    function automatic logic [18:0] rand_vppn();
        logic [18:0] v;
        case (pick(4))
            0: v = 19'h12345;
            1: v = 19'h12200;
            2: v = 19'h40a00;
            default: v = 19'h7ff01;
        endcase
        if (pick(3) == 0) begin
            v[8:0] = 9'(pick(512));
        end
        return v;
    endfunction

    function automatic logic [9:0] rand_asid();
        case (pick(3))
            0: return 10'h001;
            1: return 10'h002;
            default: return 10'h3a5;
        endcase
    endfunction

    function automatic tlb_entry_t rand_entry();
        tlb_entry_t ent;
        ent.e     = (pick(8) != 0);
        ent.vppn  = rand_vppn();
        ent.ps    = (pick(3) == 0) ? `TLB_PS_4M : `TLB_PS_4K;
        ent.asid  = rand_asid();
        ent.g     = (pick(4) == 0);
        ent.page0 = 26'($random(seed));
        ent.page1 = 26'($random(seed));
        return ent;
    endfunction

    function automatic tlb_search_req_t rand_req();
        tlb_search_req_t req;
        req.vppn     = rand_vppn();
        req.va_bit12 = 1'(pick(2));
        req.asid     = rand_asid();
        return req;
    endfunction

    // 4M pages cover the whole 8M pair while 4K pages need all bits
    function automatic logic vppn_match(tlb_entry_t ent, logic [18:0] vppn);
        if (ent.ps == `TLB_PS_4M) begin
            return ent.vppn[18:9] == vppn[18:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic tlb_search_rsp_t model_search(tlb_search_req_t req);
        tlb_search_rsp_t rsp;
        logic            odd;
        rsp = '0;
        // walk down so the lowest index ends up in rsp
        for (int i = N - 1; i >= 0; i--) begin
            if (model[i].e && vppn_match(model[i], req.vppn)
                    && (model[i].g || model[i].asid == req.asid)) begin
                odd       = (model[i].ps == `TLB_PS_4M) ? req.vppn[8] : req.va_bit12;
                rsp.found = 1'b1;
                rsp.index = IW'(i);
                rsp.ps    = model[i].ps;
                rsp.page  = odd ? model[i].page1 : model[i].page0;
            end
        end
        return rsp;
    endfunction

    function automatic logic inv_selects(tlb_entry_t ent, tlb_key_t key);
        logic asid_eq;
        logic vppn_eq;
        asid_eq = ent.asid == key.asid;
        vppn_eq = vppn_match(ent, key.vppn);
        case (key.inv_op)
            5'd0, 5'd1: return 1'b1;
            5'd2: return ent.g;
            5'd3: return !ent.g;
            5'd4: return !ent.g && asid_eq;
            5'd5: return !ent.g && asid_eq && vppn_eq;
            5'd6: return (ent.g || asid_eq) && vppn_eq;
            default: return 1'b0;
        endcase
    endfunction

    task automatic apply_model(input tlb_cmd_t c);
        case (c.op)
            `TLB_CMD_WR: begin
                model[c.index] = c.payload.entry;
            end
            `TLB_CMD_FILL: begin
                model[model_fill] = c.payload.entry;
                model_fill = IW'((int'(model_fill) + 1) % N);
            end
            `TLB_CMD_INV: begin
                if (c.payload.key.inv_op > 5'd6) begin
                    model_err = 1'b1;
                end else begin
                    for (int i = 0; i < N; i++) begin
                        if (inv_selects(model[i], c.payload.key)) begin
                            model[i].e = 1'b0;
                        end
                    end
                end
            end
            default: begin
            end
        endcase
    endtask

    // random keys on both ports against the state before the next edge
    task automatic check_ports();
        tlb_search_rsp_t exp0;
        tlb_search_rsp_t exp1;
        s0_req = rand_req();
        s1_req = rand_req();
        #1;
        exp0 = model_search(s0_req);
        exp1 = model_search(s1_req);
        if (s0_rsp !== exp0) begin
            errors++;
            $display("Error at %0t: s0_rsp expected %h got %h", $time, exp0, s0_rsp);
        end
        if (s1_rsp !== exp1) begin
            errors++;
            $display("Error at %0t: s1_rsp expected %h got %h", $time, exp1, s1_rsp);
        end
        if (inv_err !== model_err) begin
            errors++;
            $display("Error at %0t: inv_err expected %b got %b", $time, model_err, inv_err);
        end
        // result strobes are single-cycle pulses
        if ({rd_valid, srch_done} !== 2'b00) begin
            errors++;
            $display("Error at %0t: {rd_valid,srch_done} expected 00 got %b",
                     $time, {rd_valid, srch_done});
        end
    endtask

    task automatic issue(input tlb_cmd_t c);
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd       = c;
        check_ports();
        @(posedge clk);
        apply_model(c);
        #1;
        cmd_valid = 1'b0;
        cmd       = '0;
    endtask

    task automatic write_entry(input logic [2:0] op, input int idx);
        tlb_cmd_t c;
        c               = '0;
        c.op            = op;
        c.index         = IW'(idx);
        c.payload.entry = rand_entry();
        issue(c);
    endtask

    task automatic read_check(input int idx);
        tlb_cmd_t   c;
        tlb_entry_t exp;
        int         n;
        c       = '0;
        c.op    = `TLB_CMD_RD;
        c.index = IW'(idx);
        exp     = model[idx];
        issue(c);
        n = 0;
        while (!rd_valid && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rd_valid) begin
            errors++;
            $display("timeout: rd_valid never rose after a read of entry %0d", idx);
        end else begin
            if (n != 0) begin
                errors++;
                $display("rd_valid rose %0d cycles late after a read of entry %0d", n, idx);
            end
            if (rd_entry !== exp) begin
                errors++;
                $display("Error at %0t: rd_entry expected %h got %h", $time, exp, rd_entry);
            end
        end
    endtask

    task automatic search_check();
        tlb_cmd_t        c;
        tlb_search_req_t req;
        tlb_search_rsp_t exp;
        int              n;
        c                  = '0;
        c.op               = `TLB_CMD_SRCH;
        c.payload.key.vppn = rand_vppn();
        c.payload.key.asid = rand_asid();
        req.vppn           = c.payload.key.vppn;
        req.va_bit12       = 1'b0;
        req.asid           = c.payload.key.asid;
        exp                = model_search(req);
        issue(c);
        n = 0;
        while (!srch_done && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!srch_done) begin
            errors++;
            $display("timeout: srch_done never rose after a search command");
        end else begin
            if (n != 0) begin
                errors++;
                $display("srch_done rose %0d cycles late after a search command", n);
            end
            if (srch_hit !== exp.found) begin
                errors++;
                $display("Error at %0t: srch_hit expected %b got %b",
                         $time, exp.found, srch_hit);
            end
            if (srch_index !== exp.index) begin
                errors++;
                $display("Error at %0t: srch_index expected %0d got %0d",
                         $time, exp.index, srch_index);
            end
        end
    endtask

    task automatic invalidate(input logic [4:0] op);
        tlb_cmd_t c;
        c                    = '0;
        c.op                 = `TLB_CMD_INV;
        c.payload.key.inv_op = op;
        c.payload.key.vppn   = rand_vppn();
        c.payload.key.asid   = rand_asid();
        issue(c);
    endtask

    initial begin
        seed       = 26323;
        errors     = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        s0_req     = '0;
        s1_req     = '0;
        model_fill = '0;
        model_err  = 1'b0;
        for (int i = 0; i < N; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // empty TLB so every key misses
        repeat (4) begin
            @(posedge clk);
            #1;
            check_ports();
        end

        // fills past the end so the counter wraps
        for (int i = 0; i < N + 5; i++) begin
            write_entry(`TLB_CMD_FILL, 0);
        end
        for (int i = 0; i < N; i++) begin
            read_check(i);
        end

        // mixed traffic
        repeat (200) begin
            case (pick(4))
                0: write_entry(`TLB_CMD_WR, int'(pick(N)));
                1: write_entry(`TLB_CMD_FILL, 0);
                2: read_check(int'(pick(N)));
                default: search_check();
            endcase
        end

        for (int op = 0; op <= 6; op++) begin
            repeat (3) begin
                for (int i = 0; i < N; i++) begin
                    write_entry(`TLB_CMD_WR, i);
                end
                invalidate(5'(op));
                for (int i = 0; i < N; i++) begin
                    read_check(i);
                end
                repeat (4) search_check();
            end
        end

        // undefined ops leave the entries alone and latch the error
        repeat (4) begin
            invalidate(5'(7 + pick(25)));
            for (int i = 0; i < N; i++) begin
                read_check(i);
            end
            write_entry(`TLB_CMD_WR, int'(pick(N)));
            search_check();
        end

        $display("tlb_tb done with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb.f
+incdir+design
design/tlb_pkg.sv
design/tlb_store.sv
design/tlb_lookup.sv
design/tlb_inv_select.sv
design/tlb_ctrl.sv
design/tlb_top.sv
dv/tlb_tb.sv
